// ==== source/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

  typedef enum logic [2:0] {
    OP_PAUSE         = 3'd0,
    OP_PLUS          = 3'd1,
    OP_MINUS         = 3'd2,
    OP_BALLAST_P     = 3'd3,
    OP_BALLAST_N     = 3'd4,
    OP_START_ARM     = 3'd5,
    OP_SHUTDOWN      = 3'd6,
    OP_DISCHARGE_ARM = 3'd7
  } cmd_op_t;

  typedef enum logic [2:0] {
    DEC_IDLE  = 3'd0,
    DEC_START = 3'd1,
    DEC_DIS0  = 3'd2,
    DEC_DIS1  = 3'd3,
    DEC_DIS2  = 3'd4,
    DEC_ERROR = 3'd5
  } dec_state_t;

  typedef struct packed {
    logic    valid;       // One-cycle command strobe
    cmd_op_t op;
  } cmd_t;

  // All fields active high after conditioning
  typedef struct packed {
    logic [3:0] drive_err;
    logic       volt_err;
    logic       curr_err;
    logic       thermal;
    logic       stop_key;
  } fault_t;

  typedef struct packed {
    logic [3:0] top;      // Bit 0 is switch 1
    logic [3:0] bot;
    logic       plus;
    logic       minus;
    logic       pause_p;
    logic       pause_n;
  } bridge_t;

  typedef struct packed {
    logic    valid;
    cmd_op_t op;
  } bridge_req_t;

  typedef struct packed {
    logic       brk;
    logic       stop;
    logic       avv;
    logic       avi;
    logic       td;
    logic [3:0] erbd;
  } indicator_t;

  localparam int RAMP_STEPS = 15;

  localparam logic [1:0] DUTY_QUARTER = 2'd0;
  localparam logic [1:0] DUTY_HALF    = 2'd1;
  localparam logic [1:0] DUTY_3Q      = 2'd2;
  localparam logic [1:0] DUTY_FULL    = 2'd3;

endpackage

`default_nettype wire

// ==== source/input_filter.sv ====
`default_nettype none

module input_filter #(
  parameter int FILTER_LEN = 8
) (
  input  wire  clk,
  input  wire  rstn,
  input  logic i_line,
  output logic o_line
);

  logic [FILTER_LEN-1:0] hist;  // Most recent sample in bit 0

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      hist   <= '0;
      o_line <= 1'b0;
    end else begin
      hist <= {hist[FILTER_LEN-2:0], i_line};
      if (&hist) begin
        o_line <= 1'b1;         // Stable high for the whole window
      end else if (~|hist) begin
        o_line <= 1'b0;         // Stable low for the whole window
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/input_conditioner.sv ====
`default_nettype none

module input_conditioner import conv_pkg::*; #(
  parameter int FILTER_LEN = 8
) (
  input  wire        clk,
  input  wire        rstn,
  input  logic       i_strobe,
  input  logic [2:0] i_bus,
  input  fault_t     i_fault_lines,
  output cmd_t       o_cmd,
  output fault_t     o_faults
);

  // Drive faults, stop key and voltage fault are wired active low
  localparam fault_t ACTIVE_LOW = '{
    drive_err: 4'hf,
    volt_err:  1'b1,
    curr_err:  1'b0,
    thermal:   1'b0,
    stop_key:  1'b1
  };

  logic       strobe_f;
  logic       strobe_q;
  logic [2:0] bus_f;
  logic [7:0] fault_raw;
  logic [7:0] fault_f;

  assign fault_raw = i_fault_lines ^ ACTIVE_LOW;

  input_filter #(.FILTER_LEN(FILTER_LEN)) u_strobe_filter (
    .clk   (clk),
    .rstn  (rstn),
    .i_line(i_strobe),
    .o_line(strobe_f)
  );

  for (genvar i = 0; i < 3; i++) begin : g_bus
    input_filter #(.FILTER_LEN(FILTER_LEN)) u_filter (
      .clk   (clk),
      .rstn  (rstn),
      .i_line(i_bus[i]),
      .o_line(bus_f[i])
    );
  end

  for (genvar i = 0; i < 8; i++) begin : g_fault
    input_filter #(.FILTER_LEN(FILTER_LEN)) u_filter (
      .clk   (clk),
      .rstn  (rstn),
      .i_line(fault_raw[i]),
      .o_line(fault_f[i])
    );
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      strobe_q <= 1'b0;
    end else begin
      strobe_q <= strobe_f;
    end
  end

  assign o_cmd.valid = strobe_q & ~strobe_f;  // Falling edge of filtered strobe
  assign o_cmd.op    = cmd_op_t'(bus_f);
  assign o_faults    = fault_t'(fault_f);

endmodule

`default_nettype wire

// ==== source/command_decoder.sv ====
`default_nettype none

module command_decoder import conv_pkg::*; (
  input  wire         clk,
  input  wire         rstn,
  input  cmd_t        i_cmd,
  input  logic        i_trip,
  input  logic        i_busy,
  input  logic        i_done,
  input  logic        i_pending,
  output bridge_req_t o_req,
  output logic        o_start_go,
  output logic        o_shutdown,
  output logic        o_fan_on,
  output logic        o_fan_off,
  output logic        o_ready
);

  dec_state_t state;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state      <= DEC_IDLE;
      o_ready    <= 1'b0;
      o_req      <= '{valid: 1'b0, op: OP_PAUSE};
      o_start_go <= 1'b0;
      o_shutdown <= 1'b0;
      o_fan_on   <= 1'b0;
      o_fan_off  <= 1'b0;
    end else begin
      o_req.valid <= 1'b0;      // Pulses by default
      o_start_go  <= 1'b0;
      o_shutdown  <= 1'b0;
      o_fan_on    <= 1'b0;
      o_fan_off   <= 1'b0;
      if (i_trip) begin
        state   <= DEC_ERROR;   // Only reset leaves this state
        o_ready <= 1'b0;
      end else if (state != DEC_ERROR) begin
        if (i_done) begin
          o_ready <= 1'b1;      // Soft start finished
        end
        if (i_cmd.valid && !i_pending) begin
          state <= DEC_IDLE;
          case (state)
            DEC_IDLE: begin
              case (i_cmd.op)
                OP_PAUSE: begin
                  if (!i_busy) begin
                    o_req <= '{valid: 1'b1, op: OP_PAUSE};
                  end
                end
                OP_PLUS, OP_MINUS, OP_BALLAST_P, OP_BALLAST_N: begin
                  if (o_ready && !i_busy) begin
                    o_req <= '{valid: 1'b1, op: i_cmd.op};
                  end
                end
                OP_START_ARM: begin
                  state <= i_busy ? DEC_IDLE : DEC_START;
                end
                OP_DISCHARGE_ARM: begin
                  state <= i_busy ? DEC_IDLE : DEC_DIS0;
                end
                OP_SHUTDOWN: begin
                  o_shutdown <= 1'b1;
                  o_fan_off  <= 1'b1;
                  o_req      <= '{valid: 1'b1, op: OP_PAUSE};
                  o_ready    <= 1'b0;
                end
              endcase
            end
            DEC_START: begin
              if (i_cmd.op == OP_PAUSE) begin
                o_start_go <= 1'b1;
                o_fan_on   <= 1'b1;
                o_req      <= '{valid: 1'b1, op: OP_PAUSE};
              end
            end
            DEC_DIS0: state <= (i_cmd.op == OP_PAUSE) ? DEC_DIS1 : DEC_IDLE;
            DEC_DIS1: state <= (i_cmd.op == OP_DISCHARGE_ARM) ? DEC_DIS2 : DEC_IDLE;
            DEC_DIS2: begin
              if (i_cmd.op == OP_PAUSE) begin
                o_ready <= 1'b1;  // Discharge sequence complete
              end
            end
            default: state <= DEC_IDLE;
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/start_sequencer.sv ====
`default_nettype none

module start_sequencer import conv_pkg::*; #(
  parameter int STEP_CYCLES = 100_000_000,
  parameter int PWM_WIDTH   = 19
) (
  input  wire  clk,
  input  wire  rstn,
  input  logic i_go,
  input  logic i_shutdown,
  input  logic i_trip,
  output logic o_busy,
  output logic o_done,
  output logic o_start,
  output logic o_charge,
  output logic o_charge_pwm
);

  localparam int TIMER_WIDTH = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;
  localparam logic [TIMER_WIDTH-1:0] RELOAD = TIMER_WIDTH'(STEP_CYCLES - 1);
  localparam logic [4:0] LAST_STEP = 5'(RAMP_STEPS);
  localparam logic [4:0] WAIT_STEP = 5'(RAMP_STEPS + 1);

  logic [4:0]             step;       // 0 idle, 1..15 ramp, 16 final wait
  logic [TIMER_WIDTH-1:0] timer;
  logic [PWM_WIDTH-1:0]   pwm_cnt;
  logic [1:0]             duty;
  logic [1:0]             pwm_phase;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      step     <= '0;
      timer    <= '0;
      o_start  <= 1'b0;
      o_charge <= 1'b0;
      o_done   <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_shutdown || i_trip) begin
        step     <= '0;
        timer    <= '0;
        o_start  <= 1'b0;
        o_charge <= 1'b0;
      end else if (i_go) begin
        step     <= 5'd1;
        timer    <= RELOAD;
        o_start  <= 1'b0;
        o_charge <= 1'b1;
      end else if (step != '0) begin
        if (timer != '0) begin
          timer <= timer - 1'b1;
        end else if (step == WAIT_STEP) begin
          step     <= '0;
          o_charge <= 1'b0;
          o_done   <= 1'b1;
        end else begin
          if (step == LAST_STEP) begin
            o_start <= 1'b1;        // Ramp complete, final wait follows
          end
          step  <= step + 1'b1;
          timer <= RELOAD;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pwm_cnt <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
    end
  end

  always_comb begin
    if (step <= 5'd4) begin
      duty = DUTY_QUARTER;
    end else if (step <= 5'd8) begin
      duty = DUTY_HALF;
    end else if (step <= 5'd11) begin
      duty = DUTY_3Q;
    end else begin
      duty = DUTY_FULL;         // Also held through the final wait
    end
  end

  assign pwm_phase    = pwm_cnt[PWM_WIDTH-1 -: 2];
  // Level n passes n+1 quarters of the period
  assign o_charge_pwm = o_charge & (pwm_phase <= duty);
  assign o_busy       = (step != '0);

endmodule

`default_nettype wire

// ==== source/bridge_driver.sv ====
`default_nettype none

module bridge_driver import conv_pkg::*; #(
  parameter int DEAD_CYCLES = 50
) (
  input  wire         clk,
  input  wire         rstn,
  input  bridge_req_t i_req,
  input  logic        i_trip,
  output logic        o_pending,
  output bridge_t     o_bridge
);

  localparam int CNT_WIDTH = $clog2(DEAD_CYCLES + 1);

  logic [CNT_WIDTH-1:0] dead_cnt;
  bridge_t              next_pattern;
  logic                 is_drive;

  function automatic bridge_t pattern(input cmd_op_t op);
    bridge_t p;
    p = '0;
    case (op)
      OP_PLUS:      p = '{top: 4'b0001, bot: 4'b0010, plus: 1'b1, default: '0};
      OP_MINUS:     p = '{top: 4'b0010, bot: 4'b0001, minus: 1'b1, default: '0};
      OP_BALLAST_P: p = '{top: 4'b0100, bot: 4'b1000, pause_p: 1'b1, default: '0};
      OP_BALLAST_N: p = '{top: 4'b1000, bot: 4'b0100, pause_n: 1'b1, default: '0};
      default:      p = '0;
    endcase
    return p;
  endfunction

  assign is_drive = (i_req.op inside {OP_PLUS, OP_MINUS, OP_BALLAST_P, OP_BALLAST_N});

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      o_bridge  <= '0;
      o_pending <= 1'b0;
      dead_cnt  <= '0;
    end else if (i_trip) begin
      o_bridge  <= '0;          // Trip drops any queued pattern
      o_pending <= 1'b0;
      dead_cnt  <= '0;
    end else if (i_req.valid) begin
      o_bridge  <= '0;          // Dead-time gap starts with all off
      o_pending <= is_drive;
      dead_cnt  <= CNT_WIDTH'(DEAD_CYCLES);
    end else if (dead_cnt != '0) begin
      dead_cnt <= dead_cnt - 1'b1;
    end else if (o_pending) begin
      o_bridge  <= next_pattern;
      o_pending <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      next_pattern <= '0;
    end else if (i_req.valid) begin
      next_pattern <= pattern(i_req.op);
    end
  end

endmodule

`default_nettype wire

// ==== source/fault_monitor.sv ====
`default_nettype none

module fault_monitor import conv_pkg::*; (
  input  wire        clk,
  input  wire        rstn,
  input  fault_t     i_faults,
  input  logic       i_fan_on,
  input  logic       i_fan_off,
  output logic       o_trip,
  output logic       o_fan,
  output indicator_t o_ind
);

  assign o_trip = |i_faults;    // Any active fault trips

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      o_fan <= 1'b0;
    end else if (o_trip || i_fan_on) begin
      o_fan <= 1'b1;            // Cooling forced on by a trip
    end else if (i_fan_off) begin
      o_fan <= 1'b0;
    end
  end

  // Sticky indicators until reset
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      o_ind <= '0;
    end else begin
      o_ind.brk  <= o_ind.brk  | o_trip;
      o_ind.stop <= o_ind.stop | i_faults.stop_key;
      o_ind.avv  <= o_ind.avv  | i_faults.volt_err;
      o_ind.avi  <= o_ind.avi  | i_faults.curr_err;
      o_ind.td   <= o_ind.td   | i_faults.thermal;
      o_ind.erbd <= o_ind.erbd | i_faults.drive_err;
    end
  end

endmodule

`default_nettype wire

// ==== source/converter_top.sv ====
`default_nettype none

module converter_top import conv_pkg::*; #(
  parameter int FILTER_LEN  = 8,
  parameter int STEP_CYCLES = 100_000_000,
  parameter int DEAD_CYCLES = 50,
  parameter int PWM_WIDTH   = 19
) (
  input  wire        clk,
  input  wire        rstn,
  input  logic       i_strobe,
  input  logic [2:0] i_bus,
  input  fault_t     i_fault_lines,  // Raw pin polarity
  output bridge_t    o_bridge,
  output indicator_t o_ind,
  output logic       o_fan,
  output logic       o_start,
  output logic       o_charge,
  output logic       o_charge_pwm,
  output logic       o_ready
);

  cmd_t        cmd;
  fault_t      faults;
  bridge_req_t req;
  logic        trip;
  logic        busy;
  logic        done;
  logic        pending;
  logic        start_go;
  logic        shutdown;
  logic        fan_on;
  logic        fan_off;

  input_conditioner #(.FILTER_LEN(FILTER_LEN)) u_input_conditioner (
    .clk          (clk),
    .rstn         (rstn),
    .i_strobe     (i_strobe),
    .i_bus        (i_bus),
    .i_fault_lines(i_fault_lines),
    .o_cmd        (cmd),
    .o_faults     (faults)
  );

  command_decoder u_command_decoder (
    .clk       (clk),
    .rstn      (rstn),
    .i_cmd     (cmd),
    .i_trip    (trip),
    .i_busy    (busy),
    .i_done    (done),
    .i_pending (pending),
    .o_req     (req),
    .o_start_go(start_go),
    .o_shutdown(shutdown),
    .o_fan_on  (fan_on),
    .o_fan_off (fan_off),
    .o_ready   (o_ready)
  );

  start_sequencer #(
    .STEP_CYCLES(STEP_CYCLES),
    .PWM_WIDTH  (PWM_WIDTH)
  ) u_start_sequencer (
    .clk         (clk),
    .rstn        (rstn),
    .i_go        (start_go),
    .i_shutdown  (shutdown),
    .i_trip      (trip),
    .o_busy      (busy),
    .o_done      (done),
    .o_start     (o_start),
    .o_charge    (o_charge),
    .o_charge_pwm(o_charge_pwm)
  );

  bridge_driver #(.DEAD_CYCLES(DEAD_CYCLES)) u_bridge_driver (
    .clk      (clk),
    .rstn     (rstn),
    .i_req    (req),
    .i_trip   (trip),
    .o_pending(pending),
    .o_bridge (o_bridge)
  );

  fault_monitor u_fault_monitor (
    .clk      (clk),
    .rstn     (rstn),
    .i_faults (faults),
    .i_fan_on (fan_on),
    .i_fan_off(fan_off),
    .o_trip   (trip),
    .o_fan    (o_fan),
    .o_ind    (o_ind)
  );

endmodule

`default_nettype wire

// ==== sim/converter_properties.sv ====
`default_nettype none

module converter_properties import conv_pkg::*; (
  input wire     clk,
  input wire     rstn,
  input bridge_t i_bridge,
  input logic    i_charge,
  input logic    i_charge_pwm
);

  int unsigned violations = 0;  // Read by the testbench

  // One leg never conducts top and bottom together
  a_no_shoot_through: assert property (
    @(posedge clk) disable iff (!rstn) (i_bridge.top & i_bridge.bot) == 4'b0000
  ) else begin
    $error("Top and bottom switch of one leg on together, top %b bot %b",
           i_bridge.top, i_bridge.bot);
    violations++;
  end

  a_one_mode: assert property (
    @(posedge clk) disable iff (!rstn)
      $onehot0({i_bridge.plus, i_bridge.minus, i_bridge.pause_p, i_bridge.pause_n})
  ) else begin
    $error("More than one bridge mode flag high");
    violations++;
  end

  a_pwm_gated: assert property (
    @(posedge clk) disable iff (!rstn) !(i_charge_pwm && !i_charge)
  ) else begin
    $error("Charge PWM high while charge is off");
    violations++;
  end

endmodule

bind converter_top converter_properties u_converter_properties (
  .clk         (clk),
  .rstn        (rstn),
  .i_bridge    (o_bridge),
  .i_charge    (o_charge),
  .i_charge_pwm(o_charge_pwm)
);

`default_nettype wire

// ==== sim/converter_tb.sv ====
`default_nettype none

module converter_tb import conv_pkg::*; ();

  localparam int FILTER_LEN    = 4;
  localparam int STEP_CYCLES   = 40;
  localparam int DEAD_CYCLES   = 6;
  localparam int PWM_WIDTH     = 6;
  localparam int PERIOD        = 100;
  localparam int RESET_CYCLES  = 8;
  localparam int STROBE_CYCLES = 3 * FILTER_LEN;
  localparam int SETTLE_CYCLES = 3 * FILTER_LEN + DEAD_CYCLES;
  localparam int CMD_CYCLES    = STROBE_CYCLES + SETTLE_CYCLES;
  localparam int RAMP_CYCLES   = (RAMP_STEPS + 1) * STEP_CYCLES;
  localparam int NUM_DRIVE     = 16;
  localparam int NUM_MIX       = 24;
  localparam int NUM_LOCKED    = 6;
  localparam int NUM_CMDS      = NUM_DRIVE + NUM_MIX + NUM_LOCKED + 32;  // Fixed ones on top
  localparam int WATCHDOG_CYCLES = 2 * (NUM_CMDS * CMD_CYCLES + RAMP_CYCLES + 2 * RESET_CYCLES);
  localparam int QUARTER_WINDOW  = 4 * STEP_CYCLES;       // Steps 1 to 4
  localparam int PWM_TOL         = 2 ** (PWM_WIDTH - 2);  // Quarter of a PWM period
  localparam int PWM_LOW         = QUARTER_WINDOW / 4 - PWM_TOL;
  localparam int PWM_HIGH        = QUARTER_WINDOW / 4 + PWM_TOL;

  // Raw pins with no fault present
  localparam fault_t LINES_IDLE = '{
    drive_err: 4'hf,
    volt_err:  1'b1,
    curr_err:  1'b0,
    thermal:   1'b0,
    stop_key:  1'b1
  };

  logic       clk;
  logic       rstn;
  logic       i_strobe;
  logic [2:0] i_bus;
  fault_t     i_fault_lines;
  bridge_t    o_bridge;
  indicator_t o_ind;
  logic       o_fan;
  logic       o_start;
  logic       o_charge;
  logic       o_charge_pwm;
  logic       o_ready;

  dec_state_t m_state;
  logic       m_ready;
  logic       m_busy;
  logic       m_error;
  logic       m_fan;
  logic       m_start;
  logic       m_charge;
  logic       m_gap_expected;
  bridge_t    m_bridge;
  indicator_t m_ind;

  int          value_errors;
  int          other_errors;
  string       test_name;
  logic [31:0] seed;

  converter_top #(
    .FILTER_LEN (FILTER_LEN),
    .STEP_CYCLES(STEP_CYCLES),
    .DEAD_CYCLES(DEAD_CYCLES),
    .PWM_WIDTH  (PWM_WIDTH)
  ) u_converter_top (
    .clk          (clk),
    .rstn         (rstn),
    .i_strobe     (i_strobe),
    .i_bus        (i_bus),
    .i_fault_lines(i_fault_lines),
    .o_bridge     (o_bridge),
    .o_ind        (o_ind),
    .o_fan        (o_fan),
    .o_start      (o_start),
    .o_charge     (o_charge),
    .o_charge_pwm (o_charge_pwm),
    .o_ready      (o_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * PERIOD);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic cmd_op_t pick_drive_op();
    logic [31:0] r;
    r = lcg_next();
    return cmd_op_t'(3'd1 + {1'b0, r[17:16]});  // PLUS up to BALLAST_N
  endfunction

  function automatic cmd_op_t pick_any_op();
    logic [31:0] r;
    r = lcg_next();
    return cmd_op_t'(r[18:16]);
  endfunction

  function automatic bridge_t expected_pattern(input cmd_op_t op);
    bridge_t p;
    case (op)                     // top, bot, plus, minus, pause_p, pause_n
      OP_PLUS:      p = '{4'b0001, 4'b0010, 1'b1, 1'b0, 1'b0, 1'b0};
      OP_MINUS:     p = '{4'b0010, 4'b0001, 1'b0, 1'b1, 1'b0, 1'b0};
      OP_BALLAST_P: p = '{4'b0100, 4'b1000, 1'b0, 1'b0, 1'b1, 1'b0};
      OP_BALLAST_N: p = '{4'b1000, 4'b0100, 1'b0, 1'b0, 1'b0, 1'b1};
      default:      p = '0;
    endcase
    return p;
  endfunction

  task automatic clear_model();
    m_state  = DEC_IDLE;
    m_ready  = 1'b0;
    m_busy   = 1'b0;
    m_error  = 1'b0;
    m_fan    = 1'b0;
    m_start  = 1'b0;
    m_charge = 1'b0;
    m_bridge = '0;
    m_ind    = '0;
  endtask

  task automatic predict_command(input cmd_op_t op);
    m_gap_expected = 1'b0;
    if (!m_error) begin
      case (m_state)
        DEC_IDLE: begin
          if (op == OP_PAUSE) begin
            if (!m_busy) begin
              m_bridge       = '0;
              m_gap_expected = 1'b1;
            end
          end else if (op inside {OP_PLUS, OP_MINUS, OP_BALLAST_P, OP_BALLAST_N}) begin
            if (m_ready && !m_busy) begin
              m_bridge       = expected_pattern(op);
              m_gap_expected = 1'b1;
            end
          end else if (op == OP_START_ARM) begin
            m_state = m_busy ? DEC_IDLE : DEC_START;
          end else if (op == OP_DISCHARGE_ARM) begin
            m_state = m_busy ? DEC_IDLE : DEC_DIS0;
          end else begin        // Shutdown
            m_bridge       = '0;
            m_gap_expected = 1'b1;
            m_start        = 1'b0;
            m_charge       = 1'b0;
            m_busy         = 1'b0;
            m_fan          = 1'b0;
            m_ready        = 1'b0;
          end
        end
        DEC_START: begin
          m_state = DEC_IDLE;
          if (op == OP_PAUSE) begin
            m_bridge       = '0;
            m_gap_expected = 1'b1;
            m_fan          = 1'b1;
            m_start        = 1'b0;
            m_charge       = 1'b1;
            m_busy         = 1'b1;
          end
        end
        DEC_DIS0: m_state = (op == OP_PAUSE) ? DEC_DIS1 : DEC_IDLE;
        DEC_DIS1: m_state = (op == OP_DISCHARGE_ARM) ? DEC_DIS2 : DEC_IDLE;
        DEC_DIS2: begin
          m_state = DEC_IDLE;
          if (op == OP_PAUSE) begin
            m_ready = 1'b1;
          end
        end
        default: m_state = DEC_IDLE;
      endcase
    end
  endtask

  task automatic finish_ramp();
    m_busy   = 1'b0;
    m_start  = 1'b1;
    m_charge = 1'b0;
    m_ready  = 1'b1;
  endtask

  task automatic predict_trip(input logic [2:0] fault_bit);
    m_error   = 1'b1;
    m_bridge  = '0;
    m_start   = 1'b0;
    m_charge  = 1'b0;
    m_busy    = 1'b0;
    m_ready   = 1'b0;
    m_fan     = 1'b1;
    m_ind.brk = 1'b1;
    case (fault_bit)            // Bit order of fault_t
      3'd0:    m_ind.stop = 1'b1;
      3'd1:    m_ind.td   = 1'b1;
      3'd2:    m_ind.avi  = 1'b1;
      3'd3:    m_ind.avv  = 1'b1;
      default: m_ind.erbd[fault_bit[1:0]] = 1'b1;
    endcase
  endtask

  task automatic check_bridge(input bridge_t exp, input bridge_t act);
    if (act !== exp) begin
      $display("FAILED %s: o_bridge expected %h, actual %h", test_name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_ind(input indicator_t exp, input indicator_t act);
    if (act !== exp) begin
      $display("FAILED %s: o_ind expected %h, actual %h", test_name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s: %s expected %b, actual %b", test_name, what, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
      $display("FAILED %s: %s expected %0d, actual %0d", test_name, what, exp, act);
      value_errors++;
    end
  endtask

  task automatic compare_outputs();
    check_bridge(m_bridge, o_bridge);
    check_ind(m_ind, o_ind);
    check_bit("o_fan", m_fan, o_fan);
    check_bit("o_start", m_start, o_start);
    check_bit("o_charge", m_charge, o_charge);
    check_bit("o_ready", m_ready, o_ready);
    if (!m_charge) begin
      check_bit("o_charge_pwm", 1'b0, o_charge_pwm);
    end
  endtask

  task automatic apply_reset();
    rstn = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
  endtask

  task automatic pulse_strobe(input cmd_op_t op);
    i_bus    = op;
    i_strobe = 1'b1;
    repeat (STROBE_CYCLES) @(negedge clk);
    i_strobe = 1'b0;            // Command taken on this falling edge
  endtask

  task automatic settle(output logic off_seen);
    off_seen = 1'b0;
    repeat (SETTLE_CYCLES) begin
      @(negedge clk);
      if (o_bridge == '0) begin
        off_seen = 1'b1;
      end
    end
  endtask

  task automatic send_cmd(input cmd_op_t op);
    logic off_seen;
    pulse_strobe(op);
    settle(off_seen);
    predict_command(op);
    if (m_gap_expected) begin
      check_bit("dead-time gap", 1'b1, off_seen);
    end
    compare_outputs();
  endtask

  task automatic send_discharge(input cmd_op_t last_op);
    send_cmd(OP_DISCHARGE_ARM);
    send_cmd(OP_PAUSE);
    send_cmd(OP_DISCHARGE_ARM);
    send_cmd(last_op);
  endtask

  task automatic run_soft_start();
    int   wait_cycles;
    int   cycles;
    int   pwm_high;
    int   start_low;
    int   start_high;
    logic off_seen;
    test_name = "soft start";
    send_cmd(OP_START_ARM);
    pulse_strobe(OP_PAUSE);
    wait_cycles = 0;
    while (!o_charge && wait_cycles < CMD_CYCLES) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (!o_charge) begin
      $display("%s: o_charge did not rise after the start sequence", test_name);
      other_errors++;
    end
    cycles     = 0;
    pwm_high   = 0;
    start_low  = 0;
    start_high = 0;
    while (o_charge && cycles < RAMP_CYCLES + CMD_CYCLES) begin
      if (cycles < QUARTER_WINDOW && o_charge_pwm) begin
        pwm_high++;
      end
      if (o_start) begin
        start_high++;
      end else begin
        start_low++;
      end
      cycles++;
      @(negedge clk);
    end
    check_count("cycles charging before o_start", RAMP_STEPS * STEP_CYCLES, start_low);
    check_count("cycles of final wait", STEP_CYCLES, start_high);
    if (pwm_high < PWM_LOW || pwm_high > PWM_HIGH) begin
      $display("FAILED %s: o_charge_pwm high cycles expected %0d to %0d, actual %0d",
               test_name, PWM_LOW, PWM_HIGH, pwm_high);
      value_errors++;
    end
    settle(off_seen);
    predict_command(OP_PAUSE);
    finish_ramp();
    compare_outputs();
  endtask

  task automatic inject_fault(input logic [2:0] fault_bit);
    fault_t lines;
    logic   off_seen;
    lines            = LINES_IDLE;
    lines[fault_bit] = ~lines[fault_bit];  // Assert one fault at its pin polarity
    i_fault_lines    = lines;
    repeat (3 * FILTER_LEN) @(negedge clk);
    i_fault_lines = LINES_IDLE;
    settle(off_seen);
  endtask

  initial begin
    logic [31:0] r;
    cmd_op_t     op;
    seed          = 32'hc5f8_c166;
    value_errors  = 0;
    other_errors  = 0;
    rstn          = 1'b0;
    i_strobe      = 1'b0;
    i_bus         = 3'd0;
    i_fault_lines = LINES_IDLE;

    test_name = "reset";
    clear_model();
    apply_reset();
    compare_outputs();

    test_name = "drive before ready";
    repeat (3) send_cmd(pick_drive_op());

    run_soft_start();

    test_name = "random drive";
    for (int i = 0; i < NUM_DRIVE; i++) begin
      send_cmd(pick_drive_op());
    end

    test_name = "pause";
    send_cmd(OP_PAUSE);
    send_cmd(OP_PLUS);
    test_name = "shutdown";
    send_cmd(OP_SHUTDOWN);
    send_cmd(OP_MINUS);         // Not ready any more

    test_name = "broken discharge";
    send_cmd(OP_DISCHARGE_ARM);
    send_cmd(OP_PAUSE);
    send_cmd(OP_SHUTDOWN);
    send_discharge(OP_PLUS);
    check_bit("o_ready", 1'b0, o_ready);

    test_name = "discharge";
    send_discharge(OP_PAUSE);
    check_bit("o_ready", 1'b1, o_ready);

    test_name = "random commands";
    for (int i = 0; i < NUM_MIX; i++) begin
      op = pick_any_op();
      if (op == OP_START_ARM) begin
        op = OP_DISCHARGE_ARM;  // No ramp in this phase
      end
      send_cmd(op);
    end

    test_name = "fault trip";
    send_cmd(OP_PLUS);          // Leaves any discharge state
    send_discharge(OP_PAUSE);
    send_cmd(pick_drive_op());
    r = lcg_next();
    inject_fault(r[22:20]);
    predict_trip(r[22:20]);
    compare_outputs();

    test_name = "locked after trip";
    for (int i = 0; i < NUM_LOCKED; i++) begin
      send_cmd(pick_any_op());
    end

    test_name = "reset after trip";
    apply_reset();
    clear_model();
    compare_outputs();

    $display("Errors: %0d value, %0d other, %0d assertion", value_errors, other_errors,
             u_converter_top.u_converter_properties.violations);
    if (value_errors == 0 && other_errors == 0 &&
        u_converter_top.u_converter_properties.violations == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/conv_pkg.sv
source/input_filter.sv
source/input_conditioner.sv
source/command_decoder.sv
source/start_sequencer.sv
source/bridge_driver.sv
source/fault_monitor.sv
source/converter_top.sv
sim/converter_properties.sv
sim/converter_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= converter_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
